// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = sha_acc_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A $fatal in the testbench makes the binary exit nonzero, which fails this target
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
design/sha_acc_pkg.sv
design/sha_word_intake.sv
design/sha_block_pad.sv
design/sha_acc_ctrl.sv
design/sha_block_issue.sv
design/sha_acc_top.sv
verification/sha_core_stub.sv
verification/sha_acc_tb.sv

// ==== design/sha_acc_ctrl.sv ====
module sha_acc_ctrl (
  input  logic                   clk,
  input  logic                   rst_b,
  input  sha_acc_pkg::host_req_t req,
  input  logic                   accept,
  input  logic                   block_full,
  input  logic                   core_ready,
  input  logic                   digest_valid,
  input  logic                   cmd_inflight,
  output logic                   issue_clear,
  output sha_acc_pkg::pad_sel_e  pad_sel,
  output logic                   issue_init,
  output logic                   issue_next,
  output logic                   finish,
  output sha_acc_pkg::sha_fsm_e  state
);

  sha_acc_pkg::sha_fsm_e  state_d;
  sha_acc_pkg::byte_off_t last_off;

  logic extra_pad;
  logic ready_q;
  logic digest_q;

  logic arc_idle;
  logic arc_idle_block_0;
  logic arc_block_0_block_n;
  logic arc_block_0_pad0;
  logic arc_block_n_block_n;
  logic arc_block_n_pad0;
  logic arc_pad0_pad1;
  logic arc_pad0_done;
  logic arc_pad1_done;

  // ------------------------------
  // Core status
  // ------------------------------

  // The core status lags a command by a cycle, so a pulse in flight masks both
  always_comb ready_q  = core_ready & ~cmd_inflight;
  always_comb digest_q = digest_valid & ~cmd_inflight;

  // When 112 or more data bytes share the last block the length needs its own block
  always_comb last_off  = req.dlen[$bits(sha_acc_pkg::byte_off_t)-1:0];
  always_comb extra_pad = (last_off >= sha_acc_pkg::byte_off_t'(sha_acc_pkg::pad_limit));

  // ------------------------------
  // Arcs
  // ------------------------------

  // Abort wins over every other arc in every state
  always_comb arc_idle = req.abort;

  // A message starts with its first word, or with execute alone for an empty one
  always_comb arc_idle_block_0 = (state == sha_acc_pkg::sha_idle) & ~arc_idle &
                                 (accept | req.execute);

  // A full block goes out as soon as the core can take it
  always_comb arc_block_0_block_n = (state == sha_acc_pkg::sha_block_0) & ~arc_idle &
                                    block_full & ready_q;
  always_comb arc_block_n_block_n = (state == sha_acc_pkg::sha_block_n) & ~arc_idle &
                                    block_full & ready_q;

  // A message that ends on a block edge sends its last full block first
  // The pad arc also waits while a word is still being written
  always_comb arc_block_0_pad0 = (state == sha_acc_pkg::sha_block_0) & ~arc_idle &
                                 ~arc_block_0_block_n & ~block_full & ~accept &
                                 req.execute & ready_q;
  always_comb arc_block_n_pad0 = (state == sha_acc_pkg::sha_block_n) & ~arc_idle &
                                 ~arc_block_n_block_n & ~block_full & ~accept &
                                 req.execute & ready_q;

  // Length block follows when the marker filled the previous one
  always_comb arc_pad0_pad1 = (state == sha_acc_pkg::sha_pad0) & ~arc_idle &
                              extra_pad & ready_q;

  // Finished once the core reports the digest of the last padded block
  always_comb arc_pad0_done = (state == sha_acc_pkg::sha_pad0) & ~arc_idle &
                              ~extra_pad & digest_q;
  always_comb arc_pad1_done = (state == sha_acc_pkg::sha_pad1) & ~arc_idle & digest_q;

  // ------------------------------
  // Outputs toward intake and issue
  // ------------------------------

  always_comb issue_init  = arc_block_0_block_n | arc_block_0_pad0;
  always_comb issue_next  = arc_block_n_block_n | arc_block_n_pad0 | arc_pad0_pad1;
  always_comb issue_clear = arc_block_0_block_n | arc_block_n_block_n;
  always_comb finish      = arc_pad0_done | arc_pad1_done;

  always_comb begin : pad_select
    if (arc_block_0_pad0 || arc_block_n_pad0) begin
      pad_sel = sha_acc_pkg::pad_data;
    end else if (arc_pad0_pad1) begin
      pad_sel = sha_acc_pkg::pad_len_only;
    end else begin
      pad_sel = sha_acc_pkg::pad_none;
    end
  end

  // ------------------------------
  // State machine
  // ------------------------------

  always_comb begin : next_state
    state_d = state;
    unique case (state)
      sha_acc_pkg::sha_idle: begin
        if (arc_idle_block_0) state_d = sha_acc_pkg::sha_block_0;
      end
      sha_acc_pkg::sha_block_0: begin
        if (arc_idle) state_d = sha_acc_pkg::sha_idle;
        else if (arc_block_0_block_n) state_d = sha_acc_pkg::sha_block_n;
        else if (arc_block_0_pad0) state_d = sha_acc_pkg::sha_pad0;
      end
      sha_acc_pkg::sha_block_n: begin
        if (arc_idle) state_d = sha_acc_pkg::sha_idle;
        else if (arc_block_n_pad0) state_d = sha_acc_pkg::sha_pad0;
      end
      sha_acc_pkg::sha_pad0: begin
        if (arc_idle) state_d = sha_acc_pkg::sha_idle;
        else if (arc_pad0_pad1) state_d = sha_acc_pkg::sha_pad1;
        else if (arc_pad0_done) state_d = sha_acc_pkg::sha_done;
      end
      sha_acc_pkg::sha_pad1: begin
        if (arc_idle) state_d = sha_acc_pkg::sha_idle;
        else if (arc_pad1_done) state_d = sha_acc_pkg::sha_done;
      end
      sha_acc_pkg::sha_done: begin
        if (arc_idle) state_d = sha_acc_pkg::sha_idle;
      end
      default: state_d = sha_acc_pkg::sha_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= sha_acc_pkg::sha_idle;
    end else begin
      state <= state_d;
    end
  end

  // One command at a time, the pulse in flight holds off the next issue
  a_no_back_to_back_issue : assert property (
    @(posedge clk) disable iff (!rst_b)
    (issue_init || issue_next) |=> !(issue_init || issue_next)
  );

endmodule

// ==== design/sha_acc_pkg.sv ====
package sha_acc_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Host data word width in bits
  localparam int word_w = 32;

  // SHA-512 message block width in bits
  localparam int block_w = 1024;

  // Host words that make up one block
  localparam int words_per_block = block_w / word_w;

  // Bytes in one block
  localparam int bytes_per_block = block_w / 8;

  // The 128-bit message length sits in the last 16 bytes of the final block
  localparam int len_field_bytes = 16;

  // With this many data bytes or more in the last block the length no longer fits
  localparam int pad_limit = bytes_per_block - len_field_bytes;

  // ------------------------------
  // Types
  // ------------------------------

  typedef logic [word_w-1:0] word_t;

  // Message length in bytes as given by the host
  typedef logic [31:0] dlen_t;

  // Byte 0 is the most significant byte, matching SHA-2 big-endian order
  typedef logic [0:bytes_per_block-1][7:0] block_t;

  // One bit wider than the word index, the top bit flags a full block
  typedef logic [$clog2(words_per_block):0] word_ptr_t;

  // Byte position inside one block
  typedef logic [$clog2(bytes_per_block)-1:0] byte_off_t;

  // Padding action applied to the block register
  typedef enum logic [1:0] {
    pad_none     = 2'b00,
    pad_data     = 2'b01,
    pad_len_only = 2'b10
  } pad_sel_e;

  // Block and padding sequencer states
  typedef enum logic [2:0] {
    sha_idle    = 3'b000,
    sha_block_0 = 3'b001,
    sha_block_n = 3'b011,
    sha_pad0    = 3'b010,
    sha_pad1    = 3'b110,
    sha_done    = 3'b100
  } sha_fsm_e;

  // Host request, execute and abort are levels, valid is the write strobe
  typedef struct packed {
    logic  valid;
    word_t wdata;
    dlen_t dlen;
    logic  execute;
    logic  abort;
  } host_req_t;

  // Command toward the hash core, block is valid with the init or next pulse
  typedef struct packed {
    logic   init;
    logic   next;
    block_t block;
  } core_cmd_t;

endpackage

// ==== design/sha_acc_top.sv ====
module sha_acc_top (
  input  logic                   clk,
  input  logic                   rst_b,
  input  sha_acc_pkg::host_req_t req,
  output logic                   req_hold,
  input  logic                   core_ready,
  input  logic                   digest_valid,
  output sha_acc_pkg::core_cmd_t cmd,
  output logic                   done
);

  sha_acc_pkg::block_t   cur_block;
  sha_acc_pkg::block_t   padded_block;
  sha_acc_pkg::dlen_t    bytes_written;
  sha_acc_pkg::pad_sel_e pad_sel;
  sha_acc_pkg::sha_fsm_e state;

  logic accept;
  logic block_full;
  logic issue_clear;
  logic issue_init;
  logic issue_next;
  logic finish;
  logic cmd_inflight;

  // Writes are stalled while a full block waits for the core
  assign req_hold = req.valid & block_full;

  sha_word_intake u_word_intake (
    .clk          (clk),
    .rst_b        (rst_b),
    .req          (req),
    .issue_clear  (issue_clear),
    .abort        (req.abort),
    .padded_block (padded_block),
    .accept       (accept),
    .block_full   (block_full),
    .bytes_written(bytes_written),
    .block        (cur_block)
  );

  sha_block_pad u_block_pad (
    .block        (cur_block),
    .dlen         (req.dlen),
    .pad_sel      (pad_sel),
    .padded_block (padded_block)
  );

  sha_acc_ctrl u_acc_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .req          (req),
    .accept       (accept),
    .block_full   (block_full),
    .core_ready   (core_ready),
    .digest_valid (digest_valid),
    .cmd_inflight (cmd_inflight),
    .issue_clear  (issue_clear),
    .pad_sel      (pad_sel),
    .issue_init   (issue_init),
    .issue_next   (issue_next),
    .finish       (finish),
    .state        (state)
  );

  sha_block_issue u_block_issue (
    .clk          (clk),
    .rst_b        (rst_b),
    .issue_init   (issue_init),
    .issue_next   (issue_next),
    .finish       (finish),
    .abort        (req.abort),
    .block        (cur_block),
    .cmd          (cmd),
    .cmd_inflight (cmd_inflight),
    .done         (done)
  );

  // Done from the issue stage tracks the done state of the controller
  // and is never reached before the intake has seen the whole message
  a_done_consistent : assert property (
    @(posedge clk) disable iff (!rst_b)
    done |-> (state == sha_acc_pkg::sha_done) && (bytes_written >= req.dlen)
  );

endmodule

// ==== design/sha_block_issue.sv ====
module sha_block_issue (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   issue_init,
  input  logic                   issue_next,
  input  logic                   finish,
  input  logic                   abort,
  input  sha_acc_pkg::block_t    block,
  output sha_acc_pkg::core_cmd_t cmd,
  output logic                   cmd_inflight,
  output logic                   done
);

  logic init_q;
  logic next_q;

  // ------------------------------
  // Command pulses and done
  // ------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      init_q <= 1'b0;
      next_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      init_q <= issue_init;
      next_q <= issue_next;
      // Done holds through the idle wait of the host and drops only on abort
      if (abort) begin
        done <= 1'b0;
      end else if (finish) begin
        done <= 1'b1;
      end
    end
  end

  // The block register was updated by the same arc, so it lines up with the pulse
  always_comb begin
    cmd.init  = init_q;
    cmd.next  = next_q;
    cmd.block = block;
  end

  // Tells the controller that the core status is still stale
  always_comb cmd_inflight = init_q | next_q;

  // Completion is reported only with no block left on its way to the core
  a_done_no_cmd : assert property (
    @(posedge clk) disable iff (!rst_b)
    !(done && (cmd.init || cmd.next))
  );

endmodule

// ==== design/sha_block_pad.sv ====
module sha_block_pad (
  input  sha_acc_pkg::block_t   block,
  input  sha_acc_pkg::dlen_t    dlen,
  input  sha_acc_pkg::pad_sel_e pad_sel,
  output sha_acc_pkg::block_t   padded_block
);

  sha_acc_pkg::byte_off_t last_off;

  // Message length in bits, right aligned in the 128-bit length field
  logic [sha_acc_pkg::len_field_bytes*8-1:0] len_bits;

  // High when the length field still fits behind the marker byte
  logic len_fits;

  // ------------------------------
  // Length and offset
  // ------------------------------

  // Bytes of data in the last block, zero when dlen ends on a block edge
  always_comb last_off = dlen[$bits(sha_acc_pkg::byte_off_t)-1:0];

  always_comb len_fits = (last_off < sha_acc_pkg::byte_off_t'(sha_acc_pkg::pad_limit));

  // Byte count times eight, dlen is far narrower than the field
  always_comb len_bits = {{($bits(len_bits)-$bits(dlen)){1'b0}}, dlen} << 3;

  // ------------------------------
  // Padding
  // ------------------------------

  always_comb begin : pad_logic
    padded_block = block;

    unique case (pad_sel)
      sha_acc_pkg::pad_data: begin
        // Valid bytes stay, the first free byte gets the marker, the rest is cleared
        for (int b = 0; b < sha_acc_pkg::bytes_per_block; b++) begin
          if (sha_acc_pkg::byte_off_t'(b) == last_off) begin
            padded_block[b] = 8'h80;
          end else if (sha_acc_pkg::byte_off_t'(b) > last_off) begin
            padded_block[b] = 8'h00;
          end
        end
        // The length goes here only when the marker left room for it
        if (len_fits) begin
          for (int i = 0; i < sha_acc_pkg::len_field_bytes; i++) begin
            padded_block[sha_acc_pkg::pad_limit + i] =
              len_bits[(sha_acc_pkg::len_field_bytes - 1 - i) * 8 +: 8];
          end
        end
      end

      sha_acc_pkg::pad_len_only: begin
        // Extra block after a marker that left no room, zeroes then the length
        padded_block = '0;
        for (int i = 0; i < sha_acc_pkg::len_field_bytes; i++) begin
          padded_block[sha_acc_pkg::pad_limit + i] =
            len_bits[(sha_acc_pkg::len_field_bytes - 1 - i) * 8 +: 8];
        end
      end

      default: begin
        // Plain data block, passed through as it is
        padded_block = block;
      end
    endcase
  end

endmodule

// ==== design/sha_word_intake.sv ====
module sha_word_intake (
  input  logic                   clk,
  input  logic                   rst_b,
  input  sha_acc_pkg::host_req_t req,
  input  logic                   issue_clear,
  input  logic                   abort,
  input  sha_acc_pkg::block_t    padded_block,
  output logic                   accept,
  output logic                   block_full,
  output sha_acc_pkg::dlen_t     bytes_written,
  output sha_acc_pkg::block_t    block
);

  sha_acc_pkg::word_ptr_t word_ptr;
  sha_acc_pkg::block_t    block_d;

  // Word slot addressed by the low bits of the write pointer
  logic [$bits(sha_acc_pkg::word_ptr_t)-2:0] word_slot;

  // ------------------------------
  // Acceptance and fullness
  // ------------------------------

  // The pointer only reaches its top bit after the last slot was written
  // A block that holds more bytes than dlen is the final partial block
  // It must stay in place for padding and is never reported as full
  always_comb block_full = word_ptr[$bits(sha_acc_pkg::word_ptr_t)-1] &
                           ~(bytes_written > req.dlen);

  // A write is taken whenever the block still has room
  always_comb accept = req.valid & ~block_full;

  always_comb word_slot = word_ptr[$bits(sha_acc_pkg::word_ptr_t)-2:0];

  // ------------------------------
  // Pointer and byte count
  // ------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      word_ptr      <= '0;
      bytes_written <= '0;
    end else begin
      // Abort drops the whole message, an issued full block only resets the slot
      if (abort || issue_clear) begin
        word_ptr <= '0;
      end else if (accept) begin
        word_ptr <= word_ptr + 1'b1;
      end

      // The count runs over the whole message and not just one block
      if (abort) begin
        bytes_written <= '0;
      end else if (accept) begin
        bytes_written <= bytes_written + sha_acc_pkg::dlen_t'(sha_acc_pkg::word_w / 8);
      end
    end
  end

  // ------------------------------
  // Block register
  // ------------------------------

  // Without a write the register reloads the padder output
  // which is the block unchanged unless a padding arc is active
  always_comb begin : next_block
    block_d = padded_block;
    if (accept) begin
      // First byte of the host word lands on the lowest byte index of the slot
      for (int b = 0; b < sha_acc_pkg::word_w / 8; b++) begin
        block_d[word_slot * (sha_acc_pkg::word_w / 8) + b] =
          req.wdata[(sha_acc_pkg::word_w / 8 - 1 - b) * 8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    block <= block_d;
  end

  // A full block stays frozen until it is issued or the message is aborted
  // so neither a held host word nor a padding arc can touch the pending block
  a_full_block_frozen : assert property (
    @(posedge clk) disable iff (!rst_b)
    block_full |=> $stable(block)
  );

endmodule

// ==== verification/sha_acc_tb.sv ====
module sha_acc_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_msgs   = 40;
  localparam int max_len    = 400;
  localparam int max_blocks = 4;

  logic                   clk;
  logic                   rst_b;
  sha_acc_pkg::host_req_t req;
  sha_acc_pkg::core_cmd_t cmd;
  sha_acc_pkg::block_t    cap_block;
  logic                   req_hold;
  logic                   core_ready;
  logic                   digest_valid;
  logic                   done;
  logic                   cap_init;
  logic                   cap_next;
  logic                   cap_ready;
  int unsigned            cap_count;
  int unsigned            stall_len;

  logic [31:0]         rng_state;
  logic [7:0]          msg_bytes [0:max_len+3];
  sha_acc_pkg::block_t exp_blocks [0:max_blocks-1];
  int unsigned         exp_count;
  int unsigned         got_count;
  int unsigned         seen_count;
  int unsigned         hold_cycles;
  logic                digest_seen;

  // Lengths around the block edge and the 112 byte limit come first
  int unsigned corner_lens [5] = '{0, 111, 112, 126, 256};

  sha_acc_top u_sha_acc_top (
    .clk         (clk),
    .rst_b       (rst_b),
    .req         (req),
    .req_hold    (req_hold),
    .core_ready  (core_ready),
    .digest_valid(digest_valid),
    .cmd         (cmd),
    .done        (done)
  );

  sha_core_stub u_core_stub (
    .clk         (clk),
    .rst_b       (rst_b),
    .cmd         (cmd),
    .stall_len   (stall_len),
    .core_ready  (core_ready),
    .digest_valid(digest_valid),
    .cap_count   (cap_count),
    .cap_init    (cap_init),
    .cap_next    (cap_next),
    .cap_ready   (cap_ready),
    .cap_block   (cap_block)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Advances the shared generator, all callers sit in the stimulus process
  function automatic int unsigned pick_below(input int unsigned n);
    rng_state = xorshift32(rng_state);
    return rng_state % n;
  endfunction

  task automatic check_equal(input string name, input logic [sha_acc_pkg::block_w-1:0] expected,
                             input logic [sha_acc_pkg::block_w-1:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // Message bytes, the 0x80 marker, zeroes, then the bit length big-endian
  task automatic build_model(input int unsigned len);
    logic [7:0]   padded [0:max_blocks*128-1];
    logic [127:0] bit_len;
    int unsigned  total;
    total     = ((len + 17 + 127) / 128) * 128;
    exp_count = total / 128;
    for (int i = 0; i < total; i++) begin
      padded[i] = (i < len) ? msg_bytes[i] : 8'h00;
    end
    padded[len] = 8'h80;
    bit_len = {96'h0, len} << 3;
    for (int i = 0; i < 16; i++) begin
      padded[total - 16 + i] = bit_len[(15 - i) * 8 +: 8];
    end
    for (int b = 0; b < exp_count; b++) begin
      for (int i = 0; i < 128; i++) begin
        exp_blocks[b][i] = padded[b * 128 + i];
      end
    end
  endtask

  // ------------------------------
  // Cycle step and capture check
  // ------------------------------

  // Every wait goes through here, so each captured block is seen once
  task automatic next_cycle();
    @(posedge clk);
    // Digest level of the cycle that just ended, read before the core model moves it
    digest_seen = digest_valid;
    #10;
    stall_len = 1 + pick_below(40);
    if (cap_count != seen_count) begin
      seen_count = cap_count;
      // Only the first block of a message is an init command, every later one is next
      check_equal("cmd.init", got_count == 0, cap_init);
      check_equal("cmd.next", got_count != 0, cap_next);
      check_equal("core_ready", 1'b1, cap_ready);
      if (got_count < exp_count) begin
        check_equal($sformatf("cmd.block[%0d]", got_count), exp_blocks[got_count], cap_block);
      end else begin
        check_equal("block count", exp_count, got_count + 1);
      end
      got_count++;
    end
  endtask

  // Holds the word on the bus until a cycle passes without req_hold
  task automatic send_word(input logic [31:0] data);
    logic held;
    req.valid = 1'b1;
    req.wdata = data;
    held      = 1'b1;
    while (held) begin
      #1;
      held = req_hold;
      if (held) hold_cycles++;
      next_cycle();
    end
    req.valid = 1'b0;
    req.wdata = '0;
  endtask

  task automatic run_message(input int unsigned len);
    int unsigned n_words;
    for (int i = 0; i < len + 4 && i <= max_len + 3; i++) begin
      msg_bytes[i] = 8'(pick_below(256));
    end
    build_model(len);
    got_count = 0;
    req.dlen  = len;
    n_words   = (len + 3) / 4;
    // Bytes past dlen in the last word are random and must be masked
    for (int w = 0; w < n_words; w++) begin
      send_word({msg_bytes[4*w], msg_bytes[4*w+1], msg_bytes[4*w+2], msg_bytes[4*w+3]});
      repeat (pick_below(3)) next_cycle();
    end
    req.execute = 1'b1;
    while (!done) next_cycle();
    check_equal("blocks before done", exp_count, got_count);
    // The core must have reported its digest in the cycle before done rose
    check_equal("digest_valid", 1'b1, digest_seen);
    // Done must hold while execute stays up
    repeat (1 + pick_below(4)) begin
      next_cycle();
      check_equal("done", 1'b1, done);
    end
    req.execute = 1'b0;
    req.abort   = 1'b1;
    next_cycle();
    req.abort = 1'b0;
    check_equal("done", 1'b0, done);
  endtask

  // ------------------------------
  // Stimulus and watchdog
  // ------------------------------

  initial begin : stimulus
    int unsigned len;
    rng_state   = 32'h878f;
    rst_b       = 1'b0;
    req         = '0;
    stall_len   = 1;
    exp_count   = 0;
    got_count   = 0;
    seen_count  = 0;
    hold_cycles = 0;
    digest_seen = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    rst_b = 1'b1;
    next_cycle();
    for (int m = 0; m < num_msgs; m++) begin
      len = (m < 5) ? corner_lens[m] : pick_below(max_len + 1);
      run_message(len);
    end
    // Back-to-back full blocks must have stalled the host at least once
    check_equal("req_hold seen", 1'b1, hold_cycles > 0);
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin : watchdog
    repeat (num_msgs * 2000) @(posedge clk);
    $display("Error: watchdog expired before all messages were hashed");
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

// ==== verification/sha_core_stub.sv ====
module sha_core_stub (
  input  logic                   clk,
  input  logic                   rst_b,
  input  sha_acc_pkg::core_cmd_t cmd,
  input  int unsigned            stall_len,
  output logic                   core_ready,
  output logic                   digest_valid,
  output int unsigned            cap_count,
  output logic                   cap_init,
  output logic                   cap_next,
  output logic                   cap_ready,
  output sha_acc_pkg::block_t    cap_block
);

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Core model
  // ------------------------------

  // The core is idle and ready out of reset, with no digest yet
  // Each command is captured on the clock edge that ends its pulse
  // Ready and digest then drop for stall_len cycles and come back together
  initial begin : core_model
    int unsigned busy;
    logic        pulse;
    logic        ready_prev;
    core_ready   = 1'b1;
    digest_valid = 1'b0;
    cap_count    <= 0;
    cap_init     <= 1'b0;
    cap_next     <= 1'b0;
    cap_ready    <= 1'b0;
    cap_block    <= '0;
    busy         = 0;
    ready_prev   = 1'b1;
    forever begin
      @(posedge clk);
      pulse = rst_b && (cmd.init || cmd.next);
      if (pulse) begin
        cap_block <= cmd.block;
        cap_init  <= cmd.init;
        cap_next  <= cmd.next;
        // Legal only with ready high in the issue cycle and no earlier block still running
        cap_ready <= ready_prev && (busy == 0);
        cap_count <= cap_count + 1;
        busy = stall_len;
      end
      // Ready level of the cycle that just ended, the issue cycle of the next pulse
      ready_prev = core_ready;
      #10;
      if (pulse) begin
        core_ready   = 1'b0;
        digest_valid = 1'b0;
      end else if (busy > 0) begin
        // Compression rounds take a variable time in this model
        busy--;
        if (busy == 0) begin
          core_ready   = 1'b1;
          digest_valid = 1'b1;
        end
      end
    end
  end

endmodule
